//--- hw/mcu_pkg.sv
//////////////////////////////////////////////////
// mcu package: widths, vector types and the
// interrupt numbering of the always-on domain
//////////////////////////////////////////////////

package mcu_pkg;

  // always-on gpio pins
  localparam int unsigned GPIO_W = 8;

  // timer counter width
  localparam int unsigned TIMER_W = 32;

  // one source for the timer, one per gpio pin
  localparam int unsigned IRQ_NUM = 1 + GPIO_W;
  localparam int unsigned IRQ_ID_W = 4;

  // bit 0 is the timer, gpio pin k sits at bit k+1
  localparam int unsigned IRQ_ID_TIMER = 0;
  localparam int unsigned IRQ_ID_GPIO_BASE = 1;

  typedef logic [GPIO_W-1:0] gpio_t;

  typedef logic [TIMER_W-1:0] timer_t;

  typedef logic [IRQ_NUM-1:0] irq_vec_t;

  typedef logic [IRQ_ID_W-1:0] irq_id_t;

endpackage

//--- hw/pwr_pkg.sv
//////////////////////////////////////////////////
// power package: cpu domain sequencer states and
// settle timing of the isolation and reset steps
//////////////////////////////////////////////////

package pwr_pkg;

  // cycles each iso or reset step is held
  localparam int unsigned PWR_SETTLE_CYCLES = 4;

  // wide enough for PWR_SETTLE_CYCLES-1
  localparam int unsigned SETTLE_W = 3;

  typedef logic [SETTLE_W-1:0] settle_t;

  // power-down runs ISO, RST, GATE, then OFF
  // power-up runs UNGATE, UNISO, UNRST, then ON
  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_RST,
    PWR_GATE,
    PWR_OFF,
    PWR_UNGATE,
    PWR_UNISO,
    PWR_UNRST
  } pwr_state_e;

endpackage

//--- hw/ao_timer.sv
//////////////////////////////////////////////////
// always-on timer: free running counter with a
// one cycle event each time it hits the compare
//////////////////////////////////////////////////

module ao_timer (
  input  logic            clk_i,
  input  logic            reset_i,
  input  mcu_pkg::timer_t timer_cmp_i,
  output logic            timer_evt_o
);

  mcu_pkg::timer_t cnt_q;
  logic            timer_en;
  logic            cmp_hit;

  // zero compare parks the timer
  assign timer_en = (timer_cmp_i != '0);
  assign cmp_hit  = (cnt_q == timer_cmp_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (!timer_en) begin
      cnt_q <= '0;
    end else if (cmp_hit) begin
      // period restarts, cmp+1 cycles long
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign timer_evt_o = timer_en && cmp_hit;

endmodule

//--- hw/ao_gpio_intr.sv
//////////////////////////////////////////////////
// always-on gpio interrupts: pin synchronizer,
// rising edge detect and per pin enable mask
//////////////////////////////////////////////////

module ao_gpio_intr (
  input  logic           clk_i,
  input  logic           reset_i,
  input  mcu_pkg::gpio_t gpio_i,
  input  mcu_pkg::gpio_t gpio_irq_en_i,
  output mcu_pkg::gpio_t gpio_evt_o
);

  mcu_pkg::gpio_t sync1_q;
  mcu_pkg::gpio_t sync2_q;
  mcu_pkg::gpio_t prev_q;
  mcu_pkg::gpio_t evt_q;
  mcu_pkg::gpio_t rise;

  // low to high on the synchronized pins
  assign rise = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      // pins are asynchronous to clk_i
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prev_q <= '0;
      evt_q  <= '0;
    end else begin
      prev_q <= sync2_q;
      // masked pins never raise an event
      evt_q  <= rise & gpio_irq_en_i;
    end
  end

  assign gpio_evt_o = evt_q;

endmodule

//--- hw/intr_ctrl.sv
//////////////////////////////////////////////////
// interrupt controller: pending bits per source,
// lowest id first, valid/ready delivery to core
//////////////////////////////////////////////////

module intr_ctrl (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             timer_evt_i,
  input  mcu_pkg::gpio_t   gpio_evt_i,
  input  logic             cpu_on_i,
  input  logic             irq_ready_i,
  output logic             irq_valid_o,
  output mcu_pkg::irq_id_t irq_id_o,
  output logic             wake_req_o
);

  mcu_pkg::irq_vec_t pending_q;
  mcu_pkg::irq_vec_t evt_vec;
  mcu_pkg::irq_vec_t clr_vec;
  mcu_pkg::irq_id_t  pick_id;
  logic              any_pending;
  logic              xfer;

  // sources mapped to package numbering
  always_comb begin
    evt_vec = '0;
    evt_vec[mcu_pkg::IRQ_ID_TIMER] = timer_evt_i;
    for (int i = 0; i < mcu_pkg::GPIO_W; i++) begin
      evt_vec[mcu_pkg::IRQ_ID_GPIO_BASE + i] = gpio_evt_i[i];
    end
  end

  // downward scan, so the lowest set bit is kept
  always_comb begin
    pick_id = '0;
    for (int i = mcu_pkg::IRQ_NUM - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        pick_id = mcu_pkg::irq_id_t'(i);
      end
    end
  end

  assign any_pending = |pending_q;
  assign xfer        = irq_valid_o && irq_ready_i;

  // one-hot clear of the accepted id
  assign clr_vec = mcu_pkg::irq_vec_t'(xfer) << pick_id;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      // a new event on the accepted bit stays pending
      pending_q <= (pending_q & ~clr_vec) | evt_vec;
    end
  end

  // nothing is offered while the cpu domain is down
  assign irq_valid_o = any_pending && cpu_on_i;
  assign irq_id_o    = pick_id;
  assign wake_req_o  = any_pending;

endmodule

//--- hw/cpu_power_ctrl.sv
//////////////////////////////////////////////////
// cpu power sequencer: isolates, resets and gates
// the cpu domain on sleep, reverses it on wake
//////////////////////////////////////////////////

module cpu_power_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic core_sleep_i,
  input  logic wake_req_i,
  input  logic cpu_pwrgate_ack_i,
  output logic cpu_on_o,
  output logic cpu_iso_o,
  output logic cpu_rst_o,
  output logic cpu_pwrgate_o
);

  pwr_pkg::pwr_state_e state_q;
  pwr_pkg::pwr_state_e state_d;
  pwr_pkg::settle_t    settle_q;
  logic                settle_done;
  logic                on_q;
  logic                iso_q;
  logic                rst_q;
  logic                gate_q;

  assign settle_done = (settle_q == pwr_pkg::settle_t'(pwr_pkg::PWR_SETTLE_CYCLES - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      pwr_pkg::PWR_ON: begin
        // a pending interrupt keeps the domain up
        if (core_sleep_i && !wake_req_i) begin
          state_d = pwr_pkg::PWR_ISO;
        end
      end
      pwr_pkg::PWR_ISO: begin
        if (settle_done) begin
          state_d = pwr_pkg::PWR_RST;
        end
      end
      pwr_pkg::PWR_RST: begin
        if (settle_done) begin
          state_d = pwr_pkg::PWR_GATE;
        end
      end
      pwr_pkg::PWR_GATE: begin
        // switch reports the domain is off
        if (cpu_pwrgate_ack_i) begin
          state_d = pwr_pkg::PWR_OFF;
        end
      end
      pwr_pkg::PWR_OFF: begin
        if (wake_req_i) begin
          state_d = pwr_pkg::PWR_UNGATE;
        end
      end
      pwr_pkg::PWR_UNGATE: begin
        if (!cpu_pwrgate_ack_i) begin
          state_d = pwr_pkg::PWR_UNISO;
        end
      end
      pwr_pkg::PWR_UNISO: begin
        if (settle_done) begin
          state_d = pwr_pkg::PWR_UNRST;
        end
      end
      pwr_pkg::PWR_UNRST: begin
        if (settle_done) begin
          state_d = pwr_pkg::PWR_ON;
        end
      end
      default: begin
        state_d = pwr_pkg::PWR_ON;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= pwr_pkg::PWR_ON;
      settle_q <= '0;
    end else begin
      state_q <= state_d;
      // restart the hold count on every state change
      if (state_d != state_q) begin
        settle_q <= '0;
      end else if (!settle_done) begin
        settle_q <= settle_q + 1'b1;
      end
    end
  end

  // outputs follow the state they are entering
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      on_q   <= 1'b1;
      iso_q  <= 1'b0;
      rst_q  <= 1'b0;
      gate_q <= 1'b0;
    end else begin
      on_q   <= (state_d == pwr_pkg::PWR_ON);
      iso_q  <= state_d inside {pwr_pkg::PWR_ISO, pwr_pkg::PWR_RST, pwr_pkg::PWR_GATE,
                                pwr_pkg::PWR_OFF, pwr_pkg::PWR_UNGATE};
      rst_q  <= state_d inside {pwr_pkg::PWR_RST, pwr_pkg::PWR_GATE, pwr_pkg::PWR_OFF,
                                pwr_pkg::PWR_UNGATE, pwr_pkg::PWR_UNISO};
      gate_q <= state_d inside {pwr_pkg::PWR_GATE, pwr_pkg::PWR_OFF};
    end
  end

  assign cpu_on_o      = on_q;
  assign cpu_iso_o     = iso_q;
  assign cpu_rst_o     = rst_q;
  assign cpu_pwrgate_o = gate_q;

endmodule

//--- hw/mini_mcu_top.sv
//////////////////////////////////////////////////
// mini mcu top: always-on timer and gpio events,
// interrupt delivery and cpu domain power control
//////////////////////////////////////////////////

module mini_mcu_top (
  input  logic             clk_i,
  input  logic             reset_i,
  input  mcu_pkg::timer_t  timer_cmp_i,
  input  mcu_pkg::gpio_t   gpio_i,
  input  mcu_pkg::gpio_t   gpio_irq_en_i,
  input  logic             core_sleep_i,
  input  logic             irq_ready_i,
  input  logic             cpu_pwrgate_ack_i,
  output logic             irq_valid_o,
  output mcu_pkg::irq_id_t irq_id_o,
  output logic             cpu_iso_o,
  output logic             cpu_rst_o,
  output logic             cpu_pwrgate_o
);

  logic           timer_evt;
  mcu_pkg::gpio_t gpio_evt;
  logic           wake_req;
  logic           cpu_on;

  ao_timer i_ao_timer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .timer_cmp_i (timer_cmp_i),
    .timer_evt_o (timer_evt)
  );

  ao_gpio_intr i_ao_gpio_intr (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .gpio_i        (gpio_i),
    .gpio_irq_en_i (gpio_irq_en_i),
    .gpio_evt_o    (gpio_evt)
  );

  intr_ctrl i_intr_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .timer_evt_i (timer_evt),
    .gpio_evt_i  (gpio_evt),
    .cpu_on_i    (cpu_on),
    .irq_ready_i (irq_ready_i),
    .irq_valid_o (irq_valid_o),
    .irq_id_o    (irq_id_o),
    .wake_req_o  (wake_req)
  );

  // any pending interrupt wakes the cpu domain
  cpu_power_ctrl i_cpu_power_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .core_sleep_i      (core_sleep_i),
    .wake_req_i        (wake_req),
    .cpu_pwrgate_ack_i (cpu_pwrgate_ack_i),
    .cpu_on_o          (cpu_on),
    .cpu_iso_o         (cpu_iso_o),
    .cpu_rst_o         (cpu_rst_o),
    .cpu_pwrgate_o     (cpu_pwrgate_o)
  );

endmodule

//--- sim/tb_checker.sv
//////////////////////////////////////////////////
// checker: reference model of pending interrupts
// and of the cpu domain power sequence
//////////////////////////////////////////////////

module tb_checker (
  input  logic             clk_i,
  input  logic             reset_i,
  input  mcu_pkg::timer_t  timer_cmp_i,
  input  mcu_pkg::gpio_t   gpio_i,
  input  mcu_pkg::gpio_t   gpio_irq_en_i,
  input  logic             core_sleep_i,
  input  logic             irq_ready_i,
  input  logic             cpu_pwrgate_ack_i,
  input  logic             irq_valid_i,
  input  mcu_pkg::irq_id_t irq_id_i,
  input  logic             cpu_iso_i,
  input  logic             cpu_rst_i,
  input  logic             cpu_pwrgate_i,
  output int               check_cnt_o,
  output int               xfer_cnt_o,
  output int               value_err_o,
  output int               seq_err_o
);

  localparam int SETTLE = pwr_pkg::PWR_SETTLE_CYCLES;

  mcu_pkg::irq_vec_t pend_m;
  mcu_pkg::irq_vec_t clr_m;
  mcu_pkg::timer_t   cnt_m;
  mcu_pkg::gpio_t    sync1_m;
  mcu_pkg::gpio_t    sync2_m;
  mcu_pkg::gpio_t    prev_m;
  mcu_pkg::gpio_t    gpio_evt_m;
  mcu_pkg::irq_id_t  exp_id;
  logic              timer_hit;
  logic              dom_on;
  logic              exp_valid;
  int                up_wait;
  int                iso_cnt;
  int                rst_cnt;
  int                uniso_cnt;
  logic              p_iso;
  logic              p_rst;
  logic              p_gate;
  logic              p_ack;
  logic              p_sleep;
  logic              p_idle;

  // reference pick: first set bit from id 0 upward
  function automatic mcu_pkg::irq_id_t lowest_id(input mcu_pkg::irq_vec_t v);
    for (int i = 0; i < mcu_pkg::IRQ_NUM; i++) begin
      if (v[i]) begin
        return mcu_pkg::irq_id_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic value_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    value_err_o++;
  endtask

  task automatic seq_error(input string msg);
    $display("power sequence broken at time %0t: %s", $time, msg);
    seq_err_o++;
  endtask

  task automatic reset_model();
    pend_m     = '0;
    cnt_m      = '0;
    sync1_m    = '0;
    sync2_m    = '0;
    prev_m     = '0;
    gpio_evt_m = '0;
    up_wait    = 0;
    iso_cnt    = 0;
    rst_cnt    = 0;
    uniso_cnt  = 0;
    p_iso      = 1'b0;
    p_rst      = 1'b0;
    p_gate     = 1'b0;
    p_ack      = 1'b0;
    p_sleep    = 1'b0;
    p_idle     = 1'b1;
  endtask

  // edges of iso, reset and gate against the step order
  task automatic check_power_order();
    if (cpu_iso_i && !p_iso && (!p_sleep || !p_idle || cpu_rst_i || cpu_pwrgate_i)) begin
      seq_error("isolation started without sleep, with an interrupt pending or out of order");
    end
    if (cpu_rst_i && !p_rst && (!cpu_iso_i || iso_cnt < SETTLE)) begin
      seq_error($sformatf("reset asserted after only %0d cycles of isolation", iso_cnt));
    end
    if (cpu_pwrgate_i && !p_gate && (!cpu_rst_i || rst_cnt < SETTLE)) begin
      seq_error($sformatf("power gate closed after only %0d cycles of reset", rst_cnt));
    end
    if (!cpu_pwrgate_i && p_gate && (!p_ack || p_idle)) begin
      seq_error("power gate opened before the switch was off or with nothing pending");
    end
    if (!cpu_iso_i && p_iso && (cpu_pwrgate_i || p_ack || !cpu_rst_i)) begin
      seq_error("isolation released before the power switch was back on");
    end
    if (!cpu_rst_i && p_rst) begin
      if (cpu_iso_i || uniso_cnt < SETTLE) begin
        seq_error($sformatf("reset released after only %0d cycles without isolation", uniso_cnt));
      end
      // domain reports on once the reset release step is held
      up_wait = SETTLE;
    end
    iso_cnt   = (cpu_iso_i && !cpu_rst_i) ? iso_cnt + 1 : 0;
    rst_cnt   = (cpu_rst_i && cpu_iso_i && !cpu_pwrgate_i) ? rst_cnt + 1 : 0;
    uniso_cnt = (cpu_rst_i && !cpu_iso_i) ? uniso_cnt + 1 : 0;
  endtask

  initial begin
    check_cnt_o = 0;
    xfer_cnt_o  = 0;
    value_err_o = 0;
    seq_err_o   = 0;
    reset_model();
  end

  // outputs settle long before the falling edge
  always @(negedge clk_i) begin
    check_cnt_o++;
    if (reset_i) begin
      if (irq_valid_i !== 1'b0 || cpu_iso_i !== 1'b0 || cpu_rst_i !== 1'b0 ||
          cpu_pwrgate_i !== 1'b0) begin
        value_error("valid or power outputs not low during reset");
      end
      reset_model();
    end else begin
      check_power_order();
      dom_on    = !cpu_iso_i && !cpu_rst_i && !cpu_pwrgate_i && (up_wait == 0);
      exp_valid = (pend_m != '0) && dom_on;
      exp_id    = lowest_id(pend_m);
      if (up_wait > 0) begin
        up_wait--;
      end
      if (irq_valid_i !== exp_valid) begin
        value_error($sformatf("irq_valid_o is %b, expected %b", irq_valid_i, exp_valid));
      end else if (exp_valid && irq_id_i !== exp_id) begin
        value_error($sformatf("irq_id_o is %0d, expected %0d", irq_id_i, exp_id));
      end
      clr_m = '0;
      if (exp_valid && irq_ready_i) begin
        clr_m[exp_id] = 1'b1;
        xfer_cnt_o++;
      end
      p_iso   = cpu_iso_i;
      p_rst   = cpu_rst_i;
      p_gate  = cpu_pwrgate_i;
      p_ack   = cpu_pwrgate_ack_i;
      p_sleep = core_sleep_i;
      p_idle  = (pend_m == '0);
      // timer period is cmp+1 cycles, zero compare stops it
      timer_hit  = (timer_cmp_i != '0) && (cnt_m == timer_cmp_i);
      pend_m     = (pend_m & ~clr_m) | {gpio_evt_m, timer_hit};
      cnt_m      = (timer_hit || timer_cmp_i == '0) ? '0 : cnt_m + 1;
      gpio_evt_m = sync2_m & ~prev_m & gpio_irq_en_i;
      prev_m     = sync2_m;
      sync2_m    = sync1_m;
      sync1_m    = gpio_i;
    end
  end

endmodule

//--- sim/tb_mini_mcu.sv
//////////////////////////////////////////////////
// mini mcu testbench with stimulus, core model and
// power switch model around the mcu top level
//////////////////////////////////////////////////

module tb_mini_mcu;

  localparam int          CLK_HALF = 20;
  localparam int          DRV_DLY  = 5;
  localparam int          CORE_DLY = 3;
  localparam logic [31:0] SEED     = 32'he4d5f35c;

  localparam int PH_RESET = 2;
  localparam int PH_IDLE  = 8;
  localparam int PH_TIMER = 200;
  localparam int PH_GPIO  = 400;
  localparam int PH_SLEEP = 60;
  localparam int PH_HOLD  = 20;
  localparam int PH_WAKE  = 80;
  localparam int TIMEOUT_CYCLES =
    4 * (PH_RESET + 4 * PH_IDLE + PH_TIMER + PH_GPIO + PH_SLEEP + PH_HOLD + PH_WAKE);

  localparam int READY_HOLD   = 0;
  localparam int READY_ALWAYS = 1;
  localparam int READY_RANDOM = 2;

  logic             clk_i = 1'b0;
  logic             reset_i;
  mcu_pkg::timer_t  timer_cmp_i;
  mcu_pkg::gpio_t   gpio_i;
  mcu_pkg::gpio_t   gpio_irq_en_i;
  logic             core_sleep_i;
  logic             irq_ready_i;
  logic             cpu_pwrgate_ack_i;
  logic             irq_valid_o;
  mcu_pkg::irq_id_t irq_id_o;
  logic             cpu_iso_o;
  logic             cpu_rst_o;
  logic             cpu_pwrgate_o;
  int               check_cnt;
  int               xfer_cnt;
  int               value_err;
  int               seq_err;
  int               ready_mode;
  int               ack_dly;
  int               cycle_cnt;
  logic [31:0]      stim_rng;
  logic [31:0]      core_rng;

  mini_mcu_top i_mini_mcu_top (.*);

  tb_checker i_tb_checker (
    .irq_valid_i   (irq_valid_o),
    .irq_id_i      (irq_id_o),
    .cpu_iso_i     (cpu_iso_o),
    .cpu_rst_i     (cpu_rst_o),
    .cpu_pwrgate_i (cpu_pwrgate_o),
    .check_cnt_o   (check_cnt),
    .xfer_cnt_o    (xfer_cnt),
    .value_err_o   (value_err),
    .seq_err_o     (seq_err),
    .*
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #DRV_DLY;
  endtask

  // flips one pin in about a quarter of the cycles
  task automatic toggle_random_pin();
    stim_rng = lcg_step(stim_rng);
    if (stim_rng[27:26] == 2'b00) begin
      gpio_i = gpio_i ^ (mcu_pkg::gpio_t'(1) << stim_rng[30:28]);
    end
  endtask

  initial begin
    forever #CLK_HALF clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // core ready and power switch model driven ahead of the main stimulus
  always @(posedge clk_i) begin
    #CORE_DLY;
    core_rng = lcg_step(core_rng);
    case (ready_mode)
      READY_HOLD:   irq_ready_i = 1'b0;
      READY_RANDOM: irq_ready_i = (core_rng[25:24] != 2'b00);
      default:      irq_ready_i = 1'b1;
    endcase
    // switch follows the gate after 1 to 6 cycles
    if (ack_dly > 0) begin
      ack_dly--;
      if (ack_dly == 0) begin
        cpu_pwrgate_ack_i = cpu_pwrgate_o;
      end
    end else if (cpu_pwrgate_ack_i != cpu_pwrgate_o) begin
      ack_dly = 1 + int'(core_rng[18:16]) % 6;
    end
  end

  initial begin
    reset_i           = 1'b1;
    timer_cmp_i       = '0;
    gpio_i            = '0;
    gpio_irq_en_i     = '0;
    core_sleep_i      = 1'b0;
    irq_ready_i       = 1'b0;
    cpu_pwrgate_ack_i = 1'b0;
    ready_mode        = READY_ALWAYS;
    ack_dly           = 0;
    stim_rng          = SEED;
    core_rng          = SEED ^ 32'h3c3c3c3c;
    repeat (PH_RESET) next_cycle();
    reset_i = 1'b0;
    repeat (PH_IDLE) next_cycle();

    // timer alone with pin edges masked
    timer_cmp_i = 9;
    repeat (PH_TIMER) begin
      toggle_random_pin();
      next_cycle();
    end

    // some pins enabled with core stalls and short sleep requests
    gpio_irq_en_i = 8'hb7;
    timer_cmp_i   = 37;
    ready_mode    = READY_RANDOM;
    repeat (PH_GPIO) begin
      toggle_random_pin();
      core_sleep_i = (stim_rng[15:11] == 5'd0);
      next_cycle();
    end

    // quiet sources and sleep until the switch is off
    core_sleep_i  = 1'b0;
    timer_cmp_i   = '0;
    gpio_irq_en_i = '0;
    gpio_i        = '0;
    ready_mode    = READY_ALWAYS;
    repeat (PH_IDLE) next_cycle();
    core_sleep_i = 1'b1;
    while (!(cpu_pwrgate_o && cpu_pwrgate_ack_i)) next_cycle();
    repeat (PH_IDLE) next_cycle();

    // pin 3 wakes the domain while sleep is still requested
    ready_mode    = READY_HOLD;
    gpio_irq_en_i = 8'h08;
    gpio_i[3]     = 1'b1;
    while (!irq_valid_o) next_cycle();
    repeat (PH_HOLD) next_cycle();
    core_sleep_i = 1'b0;
    ready_mode   = READY_ALWAYS;
    while (irq_valid_o) next_cycle();
    repeat (PH_IDLE) next_cycle();

    if (xfer_cnt == 0) begin
      $display("no interrupt transfer was seen during the run");
    end
    $display("checks %0d, transfers %0d, value errors %0d, sequence errors %0d",
             check_cnt, xfer_cnt, value_err, seq_err);
    if (value_err == 0 && seq_err == 0 && xfer_cnt > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- mini_mcu.f
hw/mcu_pkg.sv
hw/pwr_pkg.sv
hw/ao_timer.sv
hw/ao_gpio_intr.sv
hw/intr_ctrl.sv
hw/cpu_power_ctrl.sv
hw/mini_mcu_top.sv
sim/tb_checker.sv
sim/tb_mini_mcu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mini mcu testbench with Verilator.
# Run from the project root; the exit status is 0 only on a passing run.

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mini_mcu \
  -Mdir "$BUILD_DIR" -o tb_mini_mcu -f mini_mcu.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/tb_mini_mcu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
